// File: mmu.f
rtl/mmu_cmd_pkg.sv
rtl/mmu_addr_pkg.sv
rtl/mmu_tlb.sv
rtl/mmu_dcache_array.sv
rtl/mmu_resp_ctrl.sv
rtl/mmu_top.sv
sim/mmu_tb_mem.sv
sim/mmu_tb.sv

// File: Bender.yml
package:
  name: mmu

sources:
  - files:
      - rtl/mmu_cmd_pkg.sv
      - rtl/mmu_addr_pkg.sv
      - rtl/mmu_tlb.sv
      - rtl/mmu_dcache_array.sv
      - rtl/mmu_resp_ctrl.sv
      - rtl/mmu_top.sv
  - target: simulation
    files:
      - sim/mmu_tb_mem.sv
      - sim/mmu_tb.sv

// File: sim/mmu_tb.sv
// MMU directed testbench
`timescale 1ns/100ps

module mmu_tb
   import mmu_cmd_pkg::*;
   import mmu_addr_pkg::*;
();

   localparam int vaddr_width_lp = 32;
   localparam int paddr_width_lp = 32;
   localparam int tlb_entries_lp = 4;
   localparam int sets_lp        = 64;
   localparam int vtag_width_lp  = vaddr_width_lp - page_offset_width;
   localparam int ptag_width_lp  = paddr_width_lp - page_offset_width;
   localparam int index_width_lp = $clog2(sets_lp);
   localparam int ack_timeout_lp = 200;

   logic                      clk;
   logic                      rst;
   logic                      cmd_req;
   mmu_opcode_e               cmd_op;
   logic [vaddr_width_lp-1:0] cmd_vaddr;
   logic [word_width-1:0]     cmd_data;
   logic                      cmd_ack;
   logic [word_width-1:0]     resp_data;
   mmu_exc_e                  resp_exc;
   logic                      resp_hit;
   logic                      mem_req;
   logic [paddr_width_lp-1:0] mem_addr;
   logic                      mem_we;
   logic [word_width-1:0]     mem_wdata;
   logic                      mem_ack;
   logic [word_width-1:0]     mem_rdata;
   logic [paddr_width_lp-1:0] last_addr;
   logic [paddr_width_lp-1:0] last_wr_addr;
   logic [word_width-1:0]     last_wr_data;
   int                        access_count;

   // Reference TLB, cache and memory contents
   logic                      tlb_valid [tlb_entries_lp];
   logic [vtag_width_lp-1:0]  tlb_vtag  [tlb_entries_lp];
   logic [ptag_width_lp-1:0]  tlb_ptag  [tlb_entries_lp];
   int                        tlb_ptr;
   logic                      line_valid [sets_lp];
   logic [ptag_width_lp-1:0]  line_tag   [sets_lp];
   logic [word_width-1:0]     line_data  [sets_lp];
   logic [word_width-1:0]     ref_mem [logic [paddr_width_lp-1:0]];

   logic [31:0]               lcg_state;
   int                        error_count;
   int                        check_count;

   mmu_top #(
      .vaddr_width_p (vaddr_width_lp),
      .paddr_width_p (paddr_width_lp),
      .tlb_entries_p (tlb_entries_lp),
      .sets_p        (sets_lp)
   ) mmu_top_inst (
      .clk_i       (clk),
      .rst_i       (rst),
      .cmd_req_i   (cmd_req),
      .cmd_op_i    (cmd_op),
      .cmd_vaddr_i (cmd_vaddr),
      .cmd_data_i  (cmd_data),
      .cmd_ack_o   (cmd_ack),
      .resp_data_o (resp_data),
      .resp_exc_o  (resp_exc),
      .resp_hit_o  (resp_hit),
      .mem_req_o   (mem_req),
      .mem_addr_o  (mem_addr),
      .mem_we_o    (mem_we),
      .mem_wdata_o (mem_wdata),
      .mem_ack_i   (mem_ack),
      .mem_rdata_i (mem_rdata)
   );

   mmu_tb_mem #(
      .paddr_width_p (paddr_width_lp),
      .ack_delay_p   (3)
   ) mem_model_inst (
      .clk_i          (clk),
      .rst_i          (rst),
      .mem_req_i      (mem_req),
      .mem_addr_i     (mem_addr),
      .mem_we_i       (mem_we),
      .mem_wdata_i    (mem_wdata),
      .mem_ack_o      (mem_ack),
      .mem_rdata_o    (mem_rdata),
      .last_addr_o    (last_addr),
      .last_wr_addr_o (last_wr_addr),
      .last_wr_data_o (last_wr_data),
      .access_count_o (access_count)
   );

   always #2 clk = ~clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [word_width-1:0] ref_read(input logic [paddr_width_lp-1:0] addr);
      if (ref_mem.exists(addr))
         return ref_mem[addr];
      return word_width'(addr) ^ 32'h5a5a_0000;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual)
      begin
         error_count++;
         $display("mismatch %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic tlb_lookup_model(input logic [vtag_width_lp-1:0] vtag, output logic hit,
                                   output logic [ptag_width_lp-1:0] ptag);
      hit  = 1'b0;
      ptag = '0;
      for (int i = 0; i < tlb_entries_lp; i++)
      begin
         if (tlb_valid[i] && (tlb_vtag[i] == vtag))
         begin
            hit  = 1'b1;
            ptag = tlb_ptag[i];
         end
      end
   endtask

   // Replace a matching entry in place or take the round-robin slot
   task automatic tlb_fill_model(input logic [vtag_width_lp-1:0] vtag,
                                 input logic [ptag_width_lp-1:0] ptag);
      int slot;
      slot = -1;
      for (int i = 0; i < tlb_entries_lp; i++)
      begin
         if (tlb_valid[i] && (tlb_vtag[i] == vtag))
            slot = i;
      end
      if (slot < 0)
      begin
         slot    = tlb_ptr;
         tlb_ptr = (tlb_ptr + 1) % tlb_entries_lp;
      end
      tlb_valid[slot] = 1'b1;
      tlb_vtag[slot]  = vtag;
      tlb_ptag[slot]  = ptag;
   endtask

   // One four-phase command from falling edge to falling edge
   task automatic issue_cmd(input mmu_opcode_e op, input logic [vaddr_width_lp-1:0] vaddr,
                            input logic [word_width-1:0] data, output logic [word_width-1:0] rdata,
                            output mmu_exc_e exc, output logic hit, output int latency,
                            output int release_cycles);
      int waited;
      cmd_op    = op;
      cmd_vaddr = vaddr;
      cmd_data  = data;
      cmd_req   = 1'b1;
      waited    = 0;
      do
      begin
         @(negedge clk);
         waited++;
      end
      while (!cmd_ack && (waited < ack_timeout_lp));
      if (!cmd_ack)
      begin
         error_count++;
         $display("cmd_ack_o did not rise within %0d cycles of the request", ack_timeout_lp);
      end
      rdata   = resp_data;
      exc     = resp_exc;
      hit     = resp_hit;
      latency = waited - 1;
      cmd_req = 1'b0;
      waited  = 0;
      do
      begin
         @(negedge clk);
         waited++;
      end
      while (cmd_ack && (waited < ack_timeout_lp));
      if (cmd_ack)
      begin
         error_count++;
         $display("cmd_ack_o stayed high after the request was released");
      end
      release_cycles = waited;
   endtask

   // Predict from the reference state before running and comparing
   task automatic run_cmd(input string name, input mmu_opcode_e op,
                          input logic [vaddr_width_lp-1:0] vaddr, input logic [word_width-1:0] data);
      logic [ptag_width_lp-1:0]  ptag;
      logic [paddr_width_lp-1:0] paddr;
      logic [word_width-1:0]     exp_data;
      logic [word_width-1:0]     got_data;
      mmu_exc_e                  exp_exc;
      mmu_exc_e                  got_exc;
      logic                      exp_hit;
      logic                      got_hit;
      logic                      tlb_ok;
      int                        exp_mem;
      int                        idx;
      int                        count_before;
      int                        latency;
      int                        release_cycles;
      exp_data = '0;
      exp_exc  = exc_none;
      exp_hit  = 1'b0;
      exp_mem  = 0;
      paddr    = '0;
      idx      = int'(vaddr[byte_offset_width +: index_width_lp]);
      if (op == op_tlb_fill)
         tlb_fill_model(vaddr[vaddr_width_lp-1:page_offset_width], data[ptag_width_lp-1:0]);
      else
      begin
         tlb_lookup_model(vaddr[vaddr_width_lp-1:page_offset_width], tlb_ok, ptag);
         if (!tlb_ok)
            exp_exc = exc_tlb_miss;
         else
         begin
            paddr   = {ptag, vaddr[page_offset_width-1:byte_offset_width],
                       {byte_offset_width{1'b0}}};
            exp_hit = line_valid[idx] && (line_tag[idx] == ptag);
            if (op == op_store)
            begin
               exp_data       = data;
               exp_mem        = 1;
               ref_mem[paddr] = data;
               if (exp_hit)
                  line_data[idx] = data;
            end
            else if (exp_hit)
               exp_data = line_data[idx];
            else
            begin
               exp_data        = ref_read(paddr);
               exp_mem         = 1;
               line_valid[idx] = 1'b1;
               line_tag[idx]   = ptag;
               line_data[idx]  = exp_data;
            end
         end
      end
      count_before = access_count;
      issue_cmd(op, vaddr, data, got_data, got_exc, got_hit, latency, release_cycles);
      check_value({name, " data"}, exp_data, got_data);
      check_value({name, " exception"}, 32'(exp_exc), 32'(got_exc));
      check_value({name, " hit"}, 32'(exp_hit), 32'(got_hit));
      check_value({name, " memory requests"}, exp_mem, access_count - count_before);
      check_value({name, " ack release"}, 1, release_cycles);
      if (exp_mem == 0)
         check_value({name, " ack latency"}, 3, latency);
      else
      begin
         check_value({name, " memory address"}, paddr, last_addr);
         if (op == op_store)
         begin
            check_value({name, " write address"}, paddr, last_wr_addr);
            check_value({name, " write data"}, data, last_wr_data);
         end
      end
   endtask

   task automatic test_tlb_miss();
      run_cmd("tlb_miss", op_load, 32'h0004_5678, 32'h0);
   endtask

   task automatic test_load_miss_then_hit();
      run_cmd("map_page", op_tlb_fill, 32'h0001_0000, 32'h0000_0abc);
      run_cmd("load_miss", op_load, 32'h0001_0024, 32'h0);
      run_cmd("load_hit", op_load, 32'h0001_0024, 32'h0);
   endtask

   task automatic test_store_write_through();
      run_cmd("store_cached", op_store, 32'h0001_0024, 32'hcafe_0001);
      run_cmd("store_uncached", op_store, 32'h0001_0068, 32'hbeef_0002);
      run_cmd("load_after_store_hit", op_load, 32'h0001_0024, 32'h0);
      run_cmd("load_after_store_miss", op_load, 32'h0001_0068, 32'h0);
   endtask

   task automatic test_tlb_replacement();
      logic [vtag_width_lp-1:0] vtag;
      for (int i = 0; i <= tlb_entries_lp; i++)
      begin
         vtag = 20'h00100 + 20'(i);
         run_cmd("replace_fill", op_tlb_fill, {vtag, 12'h000}, 32'h0000_0500 + i);
      end
      for (int i = 0; i <= tlb_entries_lp; i++)
      begin
         vtag = 20'h00100 + 20'(i);
         run_cmd("replace_load", op_load, {vtag, 12'h040}, 32'h0);
      end
      // New physical tag for a page that is already mapped
      run_cmd("refill_existing", op_tlb_fill, 32'h0010_3000, 32'h0000_0777);
      run_cmd("load_after_refill", op_load, 32'h0010_3040, 32'h0);
      // Other entries survive the in-place refill
      run_cmd("load_other_page", op_load, 32'h0010_1040, 32'h0);
   endtask

   task automatic test_random_access();
      logic [31:0]              r;
      logic [vtag_width_lp-1:0] vtag;
      mmu_opcode_e              op;
      for (int i = 0; i < tlb_entries_lp; i++)
      begin
         vtag = 20'h00200 + 20'(i);
         r    = lcg_next();
         run_cmd("random_fill", op_tlb_fill, {vtag, 12'h000}, {12'h000, r[19:0]});
      end
      // Few sets and several pages so lines collide often
      for (int n = 0; n < 80; n++)
      begin
         r    = lcg_next();
         vtag = (r[22:20] == 3'd0) ? 20'h3ff00 : 20'h00200 + 20'(r[25:24]);
         op   = r[16] ? op_store : op_load;
         run_cmd("random_access", op, {vtag, r[11:8], 2'b00, r[3:0], 2'b00}, lcg_next());
      end
   endtask

   initial
   begin
      clk         = 1'b0;
      rst         = 1'b1;
      cmd_req     = 1'b0;
      cmd_op      = op_load;
      cmd_vaddr   = '0;
      cmd_data    = '0;
      lcg_state   = 32'hf05d02fa;
      error_count = 0;
      check_count = 0;
      tlb_ptr     = 0;
      for (int i = 0; i < tlb_entries_lp; i++)
         tlb_valid[i] = 1'b0;
      for (int i = 0; i < sets_lp; i++)
         line_valid[i] = 1'b0;
      repeat (8) @(negedge clk);
      rst = 1'b0;

      test_tlb_miss();
      test_load_miss_then_hit();
      test_store_write_through();
      test_tlb_replacement();
      test_random_access();

      $display("%0d checks, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

// File: sim/mmu_tb_mem.sv
// Behavioral memory responder
`timescale 1ns/100ps

module mmu_tb_mem
   import mmu_addr_pkg::*;
#(
   parameter int paddr_width_p = 32,
   parameter int ack_delay_p   = 2
)
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     mem_req_i,
   input  logic [paddr_width_p-1:0] mem_addr_i,
   input  logic                     mem_we_i,
   input  logic [word_width-1:0]    mem_wdata_i,
   output logic                     mem_ack_o,
   output logic [word_width-1:0]    mem_rdata_o,
   output logic [paddr_width_p-1:0] last_addr_o,
   output logic [paddr_width_p-1:0] last_wr_addr_o,
   output logic [word_width-1:0]    last_wr_data_o,
   output int                       access_count_o
);

   logic [word_width-1:0] store_mem [logic [paddr_width_p-1:0]];
   int                    delay_cnt;

   initial
   begin
      mem_ack_o   = 1'b0;
      mem_rdata_o = '0;
   end

   // Four-phase responder, outputs change on the falling edge
   always @(negedge clk_i)
   begin
      if (rst_i)
      begin
         mem_ack_o      <= 1'b0;
         mem_rdata_o    <= '0;
         delay_cnt      <= 0;
         access_count_o <= 0;
         last_addr_o    <= '0;
         last_wr_addr_o <= '0;
         last_wr_data_o <= '0;
      end
      else if (!mem_ack_o)
      begin
         if (!mem_req_i)
            delay_cnt <= 0;
         else if (delay_cnt < ack_delay_p)
            delay_cnt <= delay_cnt + 1;
         else
         begin
            mem_ack_o      <= 1'b1;
            delay_cnt      <= 0;
            access_count_o <= access_count_o + 1;
            last_addr_o    <= mem_addr_i;
            if (mem_we_i)
            begin
               store_mem[mem_addr_i] = mem_wdata_i;
               last_wr_addr_o <= mem_addr_i;
               last_wr_data_o <= mem_wdata_i;
            end
            else if (store_mem.exists(mem_addr_i))
               mem_rdata_o <= store_mem[mem_addr_i];
            else
               mem_rdata_o <= word_width'(mem_addr_i) ^ 32'h5a5a_0000;
         end
      end
      else if (!mem_req_i)
         mem_ack_o <= 1'b0;
   end

endmodule

// File: rtl/mmu_top.sv
// MMU top level
`timescale 1ns/100ps

module mmu_top
   import mmu_cmd_pkg::*;
   import mmu_addr_pkg::*;
#(
   parameter int vaddr_width_p = 32,
   parameter int paddr_width_p = 32,
   parameter int tlb_entries_p = 4,
   parameter int sets_p        = 64
)
(
   input  logic                     clk_i,
   input  logic                     rst_i,

   input  logic                     cmd_req_i,
   input  mmu_opcode_e              cmd_op_i,
   input  logic [vaddr_width_p-1:0] cmd_vaddr_i,
   input  logic [word_width-1:0]    cmd_data_i,
   output logic                     cmd_ack_o,
   output logic [word_width-1:0]    resp_data_o,
   output mmu_exc_e                 resp_exc_o,
   output logic                     resp_hit_o,

   output logic                     mem_req_o,
   output logic [paddr_width_p-1:0] mem_addr_o,
   output logic                     mem_we_o,
   output logic [word_width-1:0]    mem_wdata_o,
   input  logic                     mem_ack_i,
   input  logic [word_width-1:0]    mem_rdata_i
);

   localparam int vtag_width_lp  = vaddr_width_p - page_offset_width;
   localparam int ptag_width_lp  = paddr_width_p - page_offset_width;
   localparam int index_width_lp = $clog2(sets_p);
   localparam int word_idx_width_lp = page_offset_width - byte_offset_width;

   logic                         lookup;
   logic [vtag_width_lp-1:0]     vtag;
   logic [index_width_lp-1:0]    rd_index;

   logic                         tlb_hit;
   logic [ptag_width_lp-1:0]     tlb_ptag;
   logic                         tlb_fill;
   logic [vtag_width_lp-1:0]     tlb_fill_vtag;
   logic [ptag_width_lp-1:0]     tlb_fill_ptag;

   logic                         line_valid;
   logic [ptag_width_lp-1:0]     line_tag;
   logic [word_width-1:0]        line_data;
   logic                         arr_wr;
   logic [word_idx_width_lp-1:0] arr_wr_index;
   logic [ptag_width_lp-1:0]     arr_wr_tag;
   logic [word_width-1:0]        arr_wr_data;

   // Virtual tag for the TLB, set index from the page offset
   assign vtag     = cmd_vaddr_i[vaddr_width_p-1:page_offset_width];
   assign rd_index = cmd_vaddr_i[byte_offset_width +: index_width_lp];

   mmu_tlb #(
      .vaddr_width_p (vaddr_width_p),
      .paddr_width_p (paddr_width_p),
      .tlb_entries_p (tlb_entries_p)
   ) mmu_tlb_inst (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .lookup_i    (lookup),
      .vtag_i      (vtag),
      .fill_i      (tlb_fill),
      .fill_vtag_i (tlb_fill_vtag),
      .fill_ptag_i (tlb_fill_ptag),
      .hit_o       (tlb_hit),
      .ptag_o      (tlb_ptag)
   );

   mmu_dcache_array #(
      .paddr_width_p (paddr_width_p),
      .sets_p        (sets_p)
   ) mmu_dcache_array_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .lookup_i   (lookup),
      .rd_index_i (rd_index),
      .wr_i       (arr_wr),
      .wr_index_i (arr_wr_index[index_width_lp-1:0]),
      .wr_tag_i   (arr_wr_tag),
      .wr_data_i  (arr_wr_data),
      .valid_o    (line_valid),
      .tag_o      (line_tag),
      .data_o     (line_data)
   );

   mmu_resp_ctrl #(
      .vaddr_width_p (vaddr_width_p),
      .paddr_width_p (paddr_width_p)
   ) mmu_resp_ctrl_inst (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .cmd_req_i       (cmd_req_i),
      .cmd_op_i        (cmd_op_i),
      .cmd_vaddr_i     (cmd_vaddr_i),
      .cmd_data_i      (cmd_data_i),
      .cmd_ack_o       (cmd_ack_o),
      .resp_data_o     (resp_data_o),
      .resp_exc_o      (resp_exc_o),
      .resp_hit_o      (resp_hit_o),
      .lookup_o        (lookup),
      .tlb_hit_i       (tlb_hit),
      .tlb_ptag_i      (tlb_ptag),
      .line_valid_i    (line_valid),
      .line_tag_i      (line_tag),
      .line_data_i     (line_data),
      .tlb_fill_o      (tlb_fill),
      .tlb_fill_vtag_o (tlb_fill_vtag),
      .tlb_fill_ptag_o (tlb_fill_ptag),
      .arr_wr_o        (arr_wr),
      .arr_wr_index_o  (arr_wr_index),
      .arr_wr_tag_o    (arr_wr_tag),
      .arr_wr_data_o   (arr_wr_data),
      .mem_req_o       (mem_req_o),
      .mem_addr_o      (mem_addr_o),
      .mem_we_o        (mem_we_o),
      .mem_wdata_o     (mem_wdata_o),
      .mem_ack_i       (mem_ack_i),
      .mem_rdata_i     (mem_rdata_i)
   );

endmodule

// File: rtl/mmu_resp_ctrl.sv
// MMU response controller
`timescale 1ns/100ps

module mmu_resp_ctrl
   import mmu_cmd_pkg::*;
   import mmu_addr_pkg::*;
#(
   parameter int vaddr_width_p = 32,
   parameter int paddr_width_p = 32
)
(
   input  logic                                          clk_i,
   input  logic                                          rst_i,

   input  logic                                          cmd_req_i,
   input  mmu_opcode_e                                   cmd_op_i,
   input  logic [vaddr_width_p-1:0]                      cmd_vaddr_i,
   input  logic [word_width-1:0]                         cmd_data_i,
   output logic                                          cmd_ack_o,
   output logic [word_width-1:0]                         resp_data_o,
   output mmu_exc_e                                      resp_exc_o,
   output logic                                          resp_hit_o,

   output logic                                          lookup_o,
   input  logic                                          tlb_hit_i,
   input  logic [paddr_width_p-page_offset_width-1:0]     tlb_ptag_i,
   input  logic                                          line_valid_i,
   input  logic [paddr_width_p-page_offset_width-1:0]     line_tag_i,
   input  logic [word_width-1:0]                         line_data_i,

   output logic                                          tlb_fill_o,
   output logic [vaddr_width_p-page_offset_width-1:0]     tlb_fill_vtag_o,
   output logic [paddr_width_p-page_offset_width-1:0]     tlb_fill_ptag_o,

   output logic                                          arr_wr_o,
   output logic [page_offset_width-byte_offset_width-1:0] arr_wr_index_o,
   output logic [paddr_width_p-page_offset_width-1:0]     arr_wr_tag_o,
   output logic [word_width-1:0]                         arr_wr_data_o,

   output logic                                          mem_req_o,
   output logic [paddr_width_p-1:0]                      mem_addr_o,
   output logic                                          mem_we_o,
   output logic [word_width-1:0]                         mem_wdata_o,
   input  logic                                          mem_ack_i,
   input  logic [word_width-1:0]                         mem_rdata_i
);

   localparam int ptag_width_lp = paddr_width_p - page_offset_width;

   ctrl_state_e               state_r;
   ctrl_state_e               state_n;

   logic [ptag_width_lp-1:0]  ptag_r;
   logic [word_width-1:0]     resp_data_r;
   mmu_exc_e                  resp_exc_r;
   logic                      resp_hit_r;

   logic                      is_store;
   logic                      line_hit;

   assign is_store = (cmd_op_i == op_store);

   // VIPT hit, line tag against the translated tag
   assign line_hit = line_valid_i && (line_tag_i == tlb_ptag_i);

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         st_idle:
            if (cmd_req_i)
               state_n = st_lookup;
         st_lookup:
            state_n = st_decide;
         st_decide:
         begin
            if ((cmd_op_i == op_tlb_fill) || !tlb_hit_i)
               state_n = st_respond;
            else if ((cmd_op_i == op_load) && line_hit)
               state_n = st_respond;
            else
               state_n = st_mem_req;
         end
         st_mem_req:
            if (mem_ack_i)
               state_n = st_mem_release;
         st_mem_release:
            if (!mem_ack_i)
               state_n = st_respond;
         st_respond:
            state_n = st_done;
         st_done:
            if (!cmd_req_i)
               state_n = st_idle;
         default:
            state_n = st_idle;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         state_r <= st_idle;
      else
         state_r <= state_n;
   end

   // Response and translated tag, captured in decide
   always_ff @(posedge clk_i)
   begin
      if (state_r == st_decide)
      begin
         ptag_r      <= tlb_ptag_i;
         resp_exc_r  <= exc_none;
         resp_hit_r  <= 1'b0;
         resp_data_r <= '0;
         if (cmd_op_i != op_tlb_fill)
         begin
            if (!tlb_hit_i)
               resp_exc_r <= exc_tlb_miss;
            else
            begin
               resp_hit_r <= line_hit;
               if (is_store)
                  resp_data_r <= cmd_data_i;
               else
                  resp_data_r <= line_data_i;
            end
         end
      end
      else if ((state_r == st_mem_req) && mem_ack_i && !is_store)
         resp_data_r <= mem_rdata_i;
   end

   // Command side
   assign cmd_ack_o   = (state_r == st_done);
   assign resp_data_o = resp_data_r;
   assign resp_exc_o  = resp_exc_r;
   assign resp_hit_o  = resp_hit_r;

   assign lookup_o = (state_r == st_lookup);

   // TLB fill, new physical tag in the low data bits
   assign tlb_fill_o      = (state_r == st_decide) && (cmd_op_i == op_tlb_fill);
   assign tlb_fill_vtag_o = cmd_vaddr_i[vaddr_width_p-1:page_offset_width];
   assign tlb_fill_ptag_o = cmd_data_i[ptag_width_lp-1:0];

   // Line refill on a load miss, line update on a store hit
   assign arr_wr_o       = (state_r == st_mem_req) && mem_ack_i && (!is_store || resp_hit_r);
   assign arr_wr_index_o = cmd_vaddr_i[page_offset_width-1:byte_offset_width];
   assign arr_wr_tag_o   = ptag_r;
   assign arr_wr_data_o  = is_store ? cmd_data_i : mem_rdata_i;

   // Memory side, word aligned physical address
   assign mem_req_o   = (state_r == st_mem_req);
   assign mem_addr_o  = {ptag_r,
                         cmd_vaddr_i[page_offset_width-1:byte_offset_width],
                         {byte_offset_width{1'b0}}};
   assign mem_we_o    = is_store;
   assign mem_wdata_o = cmd_data_i;

endmodule

// File: rtl/mmu_dcache_array.sv
// Direct-mapped data cache array
`timescale 1ns/100ps

module mmu_dcache_array
   import mmu_addr_pkg::*;
#(
   parameter int paddr_width_p = 32,
   parameter int sets_p        = 64
)
(
   input  logic                                      clk_i,
   input  logic                                      rst_i,
   input  logic                                      lookup_i,
   input  logic [$clog2(sets_p)-1:0]                 rd_index_i,
   input  logic                                      wr_i,
   input  logic [$clog2(sets_p)-1:0]                 wr_index_i,
   input  logic [paddr_width_p-page_offset_width-1:0] wr_tag_i,
   input  logic [word_width-1:0]                     wr_data_i,
   output logic                                      valid_o,
   output logic [paddr_width_p-page_offset_width-1:0] tag_o,
   output logic [word_width-1:0]                     data_o
);

   localparam int tag_width_lp = paddr_width_p - page_offset_width;

   logic [sets_p-1:0]       valid_r;
   logic [tag_width_lp-1:0] tag_mem [sets_p];
   logic [word_width-1:0]   data_mem [sets_p];

   // Valid bits and the registered valid output
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         valid_r <= '0;
         valid_o <= 1'b0;
      end
      else
      begin
         if (wr_i)
            valid_r[wr_index_i] <= 1'b1;
         if (lookup_i)
            valid_o <= valid_r[rd_index_i];
      end
   end

   // Tag and data storage, one write port
   always_ff @(posedge clk_i)
   begin
      if (wr_i)
      begin
         tag_mem[wr_index_i]  <= wr_tag_i;
         data_mem[wr_index_i] <= wr_data_i;
      end
   end

   // Synchronous read on lookup
   always_ff @(posedge clk_i)
   begin
      if (lookup_i)
      begin
         tag_o  <= tag_mem[rd_index_i];
         data_o <= data_mem[rd_index_i];
      end
   end

endmodule

// File: rtl/mmu_tlb.sv
// Fully associative TLB
`timescale 1ns/100ps

module mmu_tlb
   import mmu_addr_pkg::*;
#(
   parameter int vaddr_width_p = 32,
   parameter int paddr_width_p = 32,
   parameter int tlb_entries_p = 4
)
(
   input  logic                                      clk_i,
   input  logic                                      rst_i,
   input  logic                                      lookup_i,
   input  logic [vaddr_width_p-page_offset_width-1:0] vtag_i,
   input  logic                                      fill_i,
   input  logic [vaddr_width_p-page_offset_width-1:0] fill_vtag_i,
   input  logic [paddr_width_p-page_offset_width-1:0] fill_ptag_i,
   output logic                                      hit_o,
   output logic [paddr_width_p-page_offset_width-1:0] ptag_o
);

   localparam int vtag_width_lp = vaddr_width_p - page_offset_width;
   localparam int ptag_width_lp = paddr_width_p - page_offset_width;
   localparam int ptr_width_lp  = (tlb_entries_p > 1) ? $clog2(tlb_entries_p) : 1;

   logic [tlb_entries_p-1:0] valid_r;
   logic [vtag_width_lp-1:0] vtag_r [tlb_entries_p];
   logic [ptag_width_lp-1:0] ptag_r [tlb_entries_p];
   logic [ptr_width_lp-1:0]  rr_ptr_r;

   logic                     look_hit;
   logic [ptag_width_lp-1:0] look_ptag;
   logic                     fill_hit;
   logic [ptr_width_lp-1:0]  fill_idx;

   // Compare every entry for both the lookup and the fill tag
   always_comb
   begin
      look_hit  = 1'b0;
      look_ptag = '0;
      fill_hit  = 1'b0;
      fill_idx  = rr_ptr_r;
      for (int i = 0; i < tlb_entries_p; i++)
      begin
         if (valid_r[i] && (vtag_r[i] == vtag_i))
         begin
            look_hit  = 1'b1;
            look_ptag = ptag_r[i];
         end
         if (valid_r[i] && (vtag_r[i] == fill_vtag_i))
         begin
            fill_hit = 1'b1;
            fill_idx = ptr_width_lp'(i);
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         valid_r  <= '0;
         rr_ptr_r <= '0;
         hit_o    <= 1'b0;
      end
      else
      begin
         if (lookup_i)
            hit_o <= look_hit;
         if (fill_i)
         begin
            valid_r[fill_idx] <= 1'b1;
            // Pointer only moves when a new entry is taken
            if (!fill_hit)
            begin
               if (rr_ptr_r == ptr_width_lp'(tlb_entries_p - 1))
                  rr_ptr_r <= '0;
               else
                  rr_ptr_r <= rr_ptr_r + 1'b1;
            end
         end
      end
   end

   // Entry contents and looked-up tag
   always_ff @(posedge clk_i)
   begin
      if (fill_i)
      begin
         vtag_r[fill_idx] <= fill_vtag_i;
         ptag_r[fill_idx] <= fill_ptag_i;
      end
      if (lookup_i)
         ptag_o <= look_ptag;
   end

endmodule

// File: rtl/mmu_addr_pkg.sv
// MMU address layout
package mmu_addr_pkg;

   // Untranslated low bits of an address, 4 KiB pages
   localparam int page_offset_width = 12;

   // Width of a command, memory and cache data word
   localparam int word_width = 32;

   // Byte select bits below a word, ignored by the cache
   localparam int byte_offset_width = 2;

endpackage

// File: rtl/mmu_cmd_pkg.sv
// MMU command definitions
package mmu_cmd_pkg;

   // Command opcodes from the host
   typedef enum logic [1:0]
   {
      op_load     = 2'd0,
      op_store    = 2'd1,
      op_tlb_fill = 2'd2
   } mmu_opcode_e;

   // Exception reported with a response
   typedef enum logic [1:0]
   {
      exc_none     = 2'd0,
      exc_tlb_miss = 2'd1
   } mmu_exc_e;

   // Response controller states
   typedef enum logic [2:0]
   {
      st_idle        = 3'd0,
      st_lookup      = 3'd1,
      st_decide      = 3'd2,
      st_mem_req     = 3'd3,
      st_mem_release = 3'd4,
      st_respond     = 3'd5,
      st_done        = 3'd6
   } ctrl_state_e;

endpackage
